/* flist.f */
+incdir+logic
logic/ui_pkg.sv
logic/score_pkg.sv
logic/button_conditioner.sv
logic/mode_menu.sv
logic/score_percent.sv
logic/hex_display.sv
logic/game_top.sv
sim/game_top_tb.sv

/* Makefile */
# Verilator build and run of the game_top testbench
VERILATOR ?= verilator
TOP ?= game_top_tb
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Testbench passed

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# fails unless the pass line appears in the output
run: compile
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* sim/game_top_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// game_top testbench with clock, reset, LFSR, stimulus table,
// display capture, checks and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "game_defs.svh"

module game_top_tb
  import ui_pkg::*, score_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int DRIVE_DELAY = 2;
  localparam int DEBOUNCE = 4;
  localparam int REFRESH = 3;
  localparam int SCORE_W = `GAME_SCORE_W;
  localparam int SETTLE = DEBOUNCE + 8;
  localparam int FINISH_WAIT = 40;
  localparam int SWEEP = `GAME_DIGITS * (1 << REFRESH);
  localparam int STEP_CYCLES = 2 * SETTLE + FINISH_WAIT + SWEEP;
  localparam int N_RANDOM = 6;

  localparam btn_t BTN_NONE = 3'b000;
  localparam btn_t BTN_UP = 3'b100;
  localparam btn_t BTN_DOWN = 3'b010;
  localparam btn_t BTN_CENTER = 3'b001;

  typedef enum logic [1:0] {act_idle, act_press, act_bounce, act_finish} action_e;

  // one table row with flags as {create_enable, game_on}
  typedef struct packed {
    action_e       act;
    btn_t          btn;
    score_report_t report;
    logic [1:0]    exp_cursor;
    logic [1:0]    exp_type;
    logic [1:0]    exp_flags;
    bcd3_t         exp_pct;
  } step_t;

  logic                    clk_in;
  logic                    reset;
  btn_t                    buttons;
  logic                    game_finish;
  score_report_t           report;
  logic [6:0]              seg;
  logic [`GAME_DIGITS-1:0] an;
  logic [5:0]              led;

  step_t       steps[$];
  logic [31:0] lfsr_state;
  bit          table_built = 1'b0;

  game_top #(
    .DEBOUNCE_CYCLES(DEBOUNCE),
    .REFRESH_BITS   (REFRESH)
  ) UUT (
    .clk_in     (clk_in),
    .reset      (reset),
    .buttons    (buttons),
    .game_finish(game_finish),
    .report     (report),
    .seg        (seg),
    .an         (an),
    .led        (led)
  );

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  // galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  function automatic int take_bits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      value[i] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
    return value;
  endfunction

  // active low segments in gfedcba order
  function automatic logic [6:0] seg_of(input logic [3:0] nibble);
    case (nibble)
      4'h0:    return 7'b100_0000;
      4'h1:    return 7'b111_1001;
      4'h2:    return 7'b010_0100;
      4'h3:    return 7'b011_0000;
      4'h4:    return 7'b001_1001;
      4'h5:    return 7'b001_0010;
      4'h6:    return 7'b000_0010;
      4'h7:    return 7'b111_1000;
      4'h8:    return 7'b000_0000;
      4'h9:    return 7'b001_0000;
      4'ha:    return 7'b000_1000;
      4'hb:    return 7'b000_0011;
      4'hc:    return 7'b100_0110;
      4'hd:    return 7'b010_0001;
      4'he:    return 7'b000_0110;
      default: return 7'b000_1110;
    endcase
  endfunction

  function automatic int decode_seg(input logic [6:0] pattern);
    for (int n = 0; n < 16; n++) begin
      if (seg_of(4'(n)) == pattern) return n;
    end
    return -1;
  endfunction

  function automatic int expected_percent(input int score, input int max_score);
    if (max_score == 0) return 0;
    return (100 * score) / max_score;
  endfunction

  function automatic bcd3_t to_bcd(input int value);
    bcd3_t r;
    r.hundreds = 4'(value / 100);
    r.tens = 4'((value / 10) % 10);
    r.ones = 4'(value % 10);
    return r;
  endfunction

  function automatic step_t make_step(input action_e act, input btn_t btn, input int score,
                                      input int max_score, input int cursor, input int gtype,
                                      input int flags, input int pct);
    step_t s;
    s.act = act;
    s.btn = btn;
    s.report.score = SCORE_W'(score);
    s.report.max_score = SCORE_W'(max_score);
    s.exp_cursor = 2'(cursor);
    s.exp_type = 2'(gtype);
    s.exp_flags = 2'(flags);
    s.exp_pct = to_bcd(pct);
    return s;
  endfunction

  task automatic build_table();
    int max_v;
    int score_v;
    // up held through reset is released before row 0
    steps.push_back(make_step(act_idle, BTN_NONE, 0, 0, 0, 0, 0, 0));
    steps.push_back(make_step(act_press, BTN_UP, 0, 0, 1, 1, 0, 0));
    steps.push_back(make_step(act_press, BTN_UP, 0, 0, 2, 2, 0, 0));
    steps.push_back(make_step(act_press, BTN_UP, 0, 0, 3, 3, 0, 0));
    steps.push_back(make_step(act_press, BTN_UP, 0, 0, 3, 3, 0, 0));
    steps.push_back(make_step(act_press, BTN_DOWN, 0, 0, 2, 2, 0, 0));
    steps.push_back(make_step(act_press, BTN_DOWN, 0, 0, 1, 1, 0, 0));
    steps.push_back(make_step(act_press, BTN_DOWN, 0, 0, 0, 0, 0, 0));
    steps.push_back(make_step(act_press, BTN_DOWN, 0, 0, 0, 0, 0, 0));
    steps.push_back(make_step(act_bounce, BTN_UP, 0, 0, 0, 0, 0, 0));
    steps.push_back(make_step(act_press, BTN_UP, 0, 0, 1, 1, 0, 0));
    // create mode and then an ignored press
    steps.push_back(make_step(act_press, BTN_CENTER, 0, 0, 1, 1, 2, 0));
    steps.push_back(make_step(act_press, BTN_UP, 0, 0, 1, 1, 2, 0));
    steps.push_back(make_step(act_finish, BTN_NONE, 45, 60, 1, 1, 0, 75));
    steps.push_back(make_step(act_press, BTN_UP, 0, 0, 2, 2, 0, 0));
    steps.push_back(make_step(act_press, BTN_CENTER, 0, 0, 2, 2, 1, 0));
    steps.push_back(make_step(act_press, BTN_DOWN, 0, 0, 2, 2, 1, 0));
    steps.push_back(make_step(act_finish, BTN_NONE, 60, 60, 2, 2, 0, 100));
    steps.push_back(make_step(act_press, BTN_UP, 0, 0, 3, 3, 0, 0));
    steps.push_back(make_step(act_press, BTN_CENTER, 0, 0, 3, 3, 1, 0));
    steps.push_back(make_step(act_finish, BTN_NONE, 0, 0, 3, 3, 0, 0));
    steps.push_back(make_step(act_press, BTN_DOWN, 0, 0, 2, 2, 0, 0));
    steps.push_back(make_step(act_finish, BTN_NONE, 1, 3, 2, 2, 0, 33));
    for (int r = 0; r < N_RANDOM; r++) begin
      max_v = take_bits(SCORE_W);
      score_v = take_bits(SCORE_W);
      if (max_v == 0) begin
        score_v = 0;
      end else begin
        score_v = score_v % (max_v + 1);
      end
      steps.push_back(make_step(act_finish, BTN_NONE, score_v, max_v, 2, 2, 0,
                                expected_percent(score_v, max_v)));
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_in);
    #DRIVE_DELAY;
  endtask

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected) else begin
      $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, name, got, expected);
      abort_run();
    end
  endtask

  // one full refresh sweep with every digit decoded back to a nibble
  task automatic check_display(input step_t s);
    logic [3:0]              shown [`GAME_DIGITS];
    logic [3:0]              expected [`GAME_DIGITS];
    logic [`GAME_DIGITS-1:0] seen;
    int                      idx;
    int                      value;
    seen = '0;
    idx = 0;
    for (int c = 0; c < SWEEP; c++) begin
      wait_cycles(1);
      assert ($onehot(~an)) else begin
        $display("Error at time %0t: digit strobe %b does not select one digit", $time, an);
        abort_run();
      end
      for (int d = 0; d < `GAME_DIGITS; d++) begin
        if (!an[d]) idx = d;
      end
      value = decode_seg(seg);
      assert (value >= 0) else begin
        $display("Error at time %0t: segment pattern %b is not a hex digit", $time, seg);
        abort_run();
      end
      shown[idx] = 4'(value);
      seen[idx] = 1'b1;
    end
    assert (&seen) else begin
      $display("Error at time %0t: refresh sweep skipped a digit, seen %b", $time, seen);
      abort_run();
    end
    expected[7] = {2'b00, s.exp_cursor};
    expected[6] = {2'b00, s.exp_type};
    expected[5] = 4'd0;
    expected[4] = 4'd0;
    expected[3] = 4'd0;
    expected[2] = s.exp_pct.hundreds;
    expected[1] = s.exp_pct.tens;
    expected[0] = s.exp_pct.ones;
    for (int d = `GAME_DIGITS - 1; d >= 0; d--) begin
      check_value($sformatf("digit %0d", d), 32'(shown[d]), 32'(expected[d]));
    end
  endtask

  task automatic apply_step(input step_t s);
    case (s.act)
      act_press: begin
        buttons = s.btn;
        wait_cycles(SETTLE);
        buttons = BTN_NONE;
        wait_cycles(SETTLE);
      end
      act_bounce: begin
        // level changes every 2 cycles which is shorter than the stable window
        repeat (5) begin
          buttons = s.btn;
          wait_cycles(2);
          buttons = BTN_NONE;
          wait_cycles(2);
        end
        wait_cycles(SETTLE);
      end
      act_finish: begin
        report = s.report;
        game_finish = 1'b1;
        wait_cycles(1);
        game_finish = 1'b0;
        wait_cycles(FINISH_WAIT);
      end
      default: wait_cycles(SETTLE);
    endcase
    check_value("led", 32'(led), 32'({s.exp_flags, s.exp_type, s.exp_cursor}));
    if (s.act == act_finish || s.act == act_idle) begin
      check_display(s);
    end
  endtask

  initial begin
    reset = 1'b1;
    buttons = BTN_UP;
    game_finish = 1'b0;
    report = '0;
    lfsr_state = 32'haf6f;
    build_table();
    table_built = 1'b1;
    repeat (2) @(posedge clk_in);
    #DRIVE_DELAY;
    reset = 1'b0;
    // active type still holds type_play right after reset
    check_value("led", 32'(led), 32'(6'b00_11_00));
    // up stays held well past the stable window before it is let go
    wait_cycles(SETTLE);
    buttons = BTN_NONE;
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    $display("Testbench passed");
    $finish;
  end

  // each row fits in one full step with two spare steps for reset and slack
  initial begin
    wait (table_built);
    #((steps.size() + 2) * STEP_CYCLES * CLK_PERIOD);
    $display("Error: simulation did not finish within the watchdog time");
    abort_run();
  end

endmodule

`default_nettype wire

/* logic/game_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// menu and score top level with display and status LEDs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "game_defs.svh"

module game_top import ui_pkg::*, score_pkg::*; #(
  parameter int unsigned DEBOUNCE_CYCLES = `GAME_DEBOUNCE_CYCLES,
  parameter int unsigned REFRESH_BITS    = `GAME_REFRESH_BITS
) (
  input  logic                    clk_in,
  input  logic                    reset,
  input  btn_t                    buttons,
  input  logic                    game_finish,
  input  score_report_t           report,
  output logic [6:0]              seg,
  output logic [`GAME_DIGITS-1:0] an,
  output logic [5:0]              led
);

  btn_t          press;
  game_type_e    cursor;
  game_type_e    active_type;
  logic          game_on;
  logic          create_enable;
  bcd3_t         percent;
  display_word_u disp_word;

  button_conditioner #(
    .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
  ) u_buttons (
    .clk_in(clk_in),
    .reset (reset),
    .raw   (buttons),
    .press (press)
  );

  mode_menu u_menu (
    .clk_in       (clk_in),
    .reset        (reset),
    .press        (press),
    .game_finish  (game_finish),
    .cursor       (cursor),
    .active_type  (active_type),
    .game_on      (game_on),
    .create_enable(create_enable)
  );

  score_percent u_score (
    .clk_in     (clk_in),
    .reset      (reset),
    .game_finish(game_finish),
    .report     (report),
    .percent    (percent)
  );

  // cursor, type, three blank zeros, then the percentage
  always_comb begin
    disp_word.fields.cursor    = {2'b00, cursor};
    disp_word.fields.game_type = {2'b00, active_type};
    disp_word.fields.pad       = '0;
    disp_word.fields.percent   = percent;
  end

  hex_display #(
    .REFRESH_BITS(REFRESH_BITS)
  ) u_display (
    .clk_in(clk_in),
    .reset (reset),
    .word  (disp_word),
    .seg   (seg),
    .an    (an)
  );

  assign led = {create_enable, game_on, active_type, cursor};

endmodule

`default_nettype wire

/* logic/hex_display.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multiplexed eight-digit seven-segment driver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "game_defs.svh"

module hex_display import score_pkg::*; #(
  parameter int unsigned REFRESH_BITS = `GAME_REFRESH_BITS
) (
  input  logic                    clk_in,
  input  logic                    reset,
  input  display_word_u           word,
  output logic [6:0]              seg,
  output logic [`GAME_DIGITS-1:0] an
);

  localparam int SEL_W = $clog2(`GAME_DIGITS);

  logic [REFRESH_BITS+SEL_W-1:0] refresh_q;
  logic [SEL_W-1:0]              slot;
  logic [SEL_W-1:0]              digit_idx;

  // active low, bit order gfedcba
  function automatic logic [6:0] hex_to_seg(input logic [3:0] nibble);
    case (nibble)
      4'h0:    return 7'b100_0000;
      4'h1:    return 7'b111_1001;
      4'h2:    return 7'b010_0100;
      4'h3:    return 7'b011_0000;
      4'h4:    return 7'b001_1001;
      4'h5:    return 7'b001_0010;
      4'h6:    return 7'b000_0010;
      4'h7:    return 7'b111_1000;
      4'h8:    return 7'b000_0000;
      4'h9:    return 7'b001_0000;
      4'ha:    return 7'b000_1000;
      4'hb:    return 7'b000_0011;
      4'hc:    return 7'b100_0110;
      4'hd:    return 7'b010_0001;
      4'he:    return 7'b000_0110;
      default: return 7'b000_1110;
    endcase
  endfunction

  // top counter bits pick the slot, leftmost digit first
  assign slot = refresh_q[REFRESH_BITS +: SEL_W];
  assign digit_idx = SEL_W'(`GAME_DIGITS - 1) - slot;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      refresh_q <= '0;
      an        <= ~(`GAME_DIGITS'(1) << (`GAME_DIGITS - 1));
    end else begin
      refresh_q <= refresh_q + 1'b1;
      an        <= ~(`GAME_DIGITS'(1) << digit_idx);
    end
  end

  always_ff @(posedge clk_in) begin
    seg <= hex_to_seg(word.digits[digit_idx]);
  end

  a_one_strobe: assert property (
    @(posedge clk_in) disable iff (reset)
    $onehot(~an)
  );

endmodule

`default_nettype wire

/* logic/score_percent.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// score over max score as a three-digit BCD percentage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "game_defs.svh"

module score_percent import score_pkg::*; (
  input  logic          clk_in,
  input  logic          reset,
  input  logic          game_finish,
  input  score_report_t report,
  output bcd3_t         percent
);

  localparam int SCALE_W = $clog2(`GAME_PERCENT_SCALE + 1);
  localparam int DIV_W = `GAME_SCORE_W + SCALE_W;

  logic                     finish_q;
  logic                     finish_edge;
  logic                     busy_q;
  logic [1:0]               index_q;
  logic [DIV_W-1:0]         dividend_q;
  logic [`GAME_SCORE_W-1:0] divisor_q;
  logic [SCALE_W-1:0]       pow10;
  logic [DIV_W-1:0]         step;
  logic                     fits;

  assign finish_edge = game_finish & ~finish_q;

  // weight of the digit being worked on
  always_comb begin
    case (index_q)
      2'd2:    pow10 = SCALE_W'(100);
      2'd1:    pow10 = SCALE_W'(10);
      2'd0:    pow10 = SCALE_W'(1);
      default: pow10 = '0;
    endcase
  end

  assign step = DIV_W'(divisor_q) * DIV_W'(pow10);
  assign fits = (divisor_q != '0) && (dividend_q >= step);

  always_ff @(posedge clk_in) begin
    if (finish_edge) begin
      dividend_q <= DIV_W'(report.score) * DIV_W'(`GAME_PERCENT_SCALE);
      divisor_q  <= report.max_score;
    end else if (busy_q && fits) begin
      dividend_q <= dividend_q - step;
    end
  end

  always_ff @(posedge clk_in) begin
    if (reset) begin
      finish_q <= 1'b0;
      busy_q   <= 1'b0;
      index_q  <= 2'd0;
      percent  <= '0;
    end else begin
      finish_q <= game_finish;
      if (finish_edge) begin
        busy_q  <= 1'b1;
        index_q <= 2'd2;
        percent <= '0;
      end else if (busy_q) begin
        if (fits) begin
          case (index_q)
            2'd2:    percent.hundreds <= percent.hundreds + 4'd1;
            2'd1:    percent.tens <= percent.tens + 4'd1;
            default: percent.ones <= percent.ones + 4'd1;
          endcase
        end else if (index_q != 2'd0) begin
          index_q <= index_q - 2'd1;
        end else begin
          // ones digit done
          busy_q <= 1'b0;
        end
      end
    end
  end

  a_bcd_digits: assert property (
    @(posedge clk_in) disable iff (reset)
    percent.hundreds <= 4'd9 && percent.tens <= 4'd9 && percent.ones <= 4'd9
  );

  a_score_in_range: assert property (
    @(posedge clk_in) disable iff (reset)
    finish_edge |-> report.score <= report.max_score
  );

endmodule

`default_nettype wire

/* logic/mode_menu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mode menu cursor and menu/active state machine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "game_defs.svh"

module mode_menu import ui_pkg::*; (
  input  logic       clk_in,
  input  logic       reset,
  input  btn_t       press,
  input  logic       game_finish,
  output game_type_e cursor,
  output game_type_e active_type,
  output logic       game_on,
  output logic       create_enable
);

  localparam game_type_e MENU_TOP = game_type_e'(`GAME_MENU_TOP);
  localparam game_type_e MENU_BOTTOM = game_type_e'(`GAME_MENU_BOTTOM);

  menu_state_e state_q;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      state_q     <= state_menu;
      cursor      <= MENU_BOTTOM;
      active_type <= type_play;
    end else begin
      case (state_q)
        state_menu: begin
          // saturating cursor, up wins over down
          if (press.up && cursor != MENU_TOP) begin
            cursor <= game_type_e'(cursor + 2'd1);
          end else if (press.down && cursor != MENU_BOTTOM) begin
            cursor <= game_type_e'(cursor - 2'd1);
          end
          active_type <= cursor;
          if (press.center) begin
            state_q <= state_active;
          end
        end
        state_active: begin
          // buttons ignored until the game reports back
          if (game_finish) begin
            state_q <= state_menu;
          end
        end
        default: state_q <= state_menu;
      endcase
    end
  end

  assign game_on = (state_q == state_active) &&
                   (active_type == type_learn || active_type == type_play);
  assign create_enable = (state_q == state_active) && (active_type == type_create);

  a_exclusive_modes: assert property (
    @(posedge clk_in) disable iff (reset)
    !(game_on && create_enable)
  );

endmodule

`default_nettype wire

/* logic/button_conditioner.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-button synchronizer, debounce counter and press pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "game_defs.svh"

module button_conditioner import ui_pkg::*; #(
  parameter int unsigned DEBOUNCE_CYCLES = `GAME_DEBOUNCE_CYCLES
) (
  input  logic clk_in,
  input  logic reset,
  input  btn_t raw,
  output btn_t press
);

  localparam int STAGES = `GAME_SYNC_STAGES;
  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEBOUNCE_CYCLES);
  localparam int NUM_BTN = $bits(btn_t);

  logic [NUM_BTN-1:0] raw_bits;
  logic [NUM_BTN-1:0] press_bits;

  assign raw_bits = raw;
  assign press = press_bits;

  for (genvar i = 0; i < NUM_BTN; i++) begin : g_btn
    logic [STAGES-1:0] sync_q;
    logic              synced;
    logic              sample_q;
    logic              clean_q;
    logic              clean_prev_q;
    logic [CNT_W-1:0]  count_q;

    assign synced = sync_q[STAGES-1];

    always_ff @(posedge clk_in) begin
      if (reset) begin
        // start from the current level so a held button stays quiet
        sync_q       <= {STAGES{raw_bits[i]}};
        sample_q     <= synced;
        clean_q      <= synced;
        clean_prev_q <= synced;
        count_q      <= '0;
      end else begin
        sync_q       <= {sync_q[STAGES-2:0], raw_bits[i]};
        clean_prev_q <= clean_q;
        if (synced != sample_q) begin
          // bounce, restart the stable window
          sample_q <= synced;
          count_q  <= '0;
        end else if (count_q == CNT_MAX) begin
          clean_q <= sample_q;
        end else begin
          count_q <= count_q + CNT_W'(1);
        end
      end
    end

    // rising edge of the clean level
    assign press_bits[i] = clean_q & ~clean_prev_q;

    a_single_pulse: assert property (
      @(posedge clk_in) disable iff (reset)
      press_bits[i] |=> !press_bits[i]
    );
  end

endmodule

`default_nettype wire

/* logic/score_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// score report, BCD percentage and display word types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "game_defs.svh"

package score_pkg;

  typedef struct packed {
    logic [`GAME_SCORE_W-1:0] score;
    logic [`GAME_SCORE_W-1:0] max_score;
  } score_report_t;

  typedef struct packed {
    logic [3:0] hundreds;
    logic [3:0] tens;
    logic [3:0] ones;
  } bcd3_t;

  // named layout, cursor on the leftmost digit
  typedef struct packed {
    logic [3:0]  cursor;
    logic [3:0]  game_type;
    logic [11:0] pad;
    bcd3_t       percent;
  } fields_t;

  // same word seen by the display as nibbles, digit 7 in the top bits
  typedef union packed {
    fields_t                        fields;
    logic [`GAME_DIGITS-1:0][3:0]   digits;
  } display_word_u;

endpackage

`default_nettype wire

/* logic/ui_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// button bundle, game type and menu state types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ui_pkg;

  // raw levels or press pulses
  typedef struct packed {
    logic up;
    logic down;
    logic center;
  } btn_t;

  typedef enum logic [1:0] {
    type_keyboard = 2'd0,
    type_create   = 2'd1,
    type_learn    = 2'd2,
    type_play     = 2'd3
  } game_type_e;

  typedef enum logic {
    state_menu   = 1'b0,
    state_active = 1'b1
  } menu_state_e;

endpackage

`default_nettype wire

/* logic/game_defs.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, synchronizer depth, debounce and refresh defaults, menu bounds
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

`define GAME_SCORE_W 12
`define GAME_SYNC_STAGES 3
// about 10 ms at 100 MHz, fits a 20-bit count
`define GAME_DEBOUNCE_CYCLES 1000000
`define GAME_REFRESH_BITS 14
`define GAME_DIGITS 8
`define GAME_PERCENT_SCALE 100

// cursor limits of the mode menu
`define GAME_MENU_BOTTOM 2'd0
`define GAME_MENU_TOP 2'd3

`endif
